// ==== hdl/filter_cond_pkg.sv ====
// Shared widths and encodings; PACKET_W must stay the sum of the data, address and route widths
`default_nettype none

package filter_cond_pkg;

    // ------------------------------------------------------------------------
    // Packet fields
    // ------------------------------------------------------------------------
    typedef logic [31:0] data_t;
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  route_t;
    typedef logic [15:0] count_t;

    // Unsigned compare between packet data and operand
    typedef enum logic [1:0] {
        CMP_LT = 2'd0,
        CMP_EQ = 2'd1,
        CMP_GT = 2'd2,
        CMP_NE = 2'd3
    } cmp_op_e;

    typedef enum logic [3:0] {
        CTRL_RESET    = 4'd0,
        CTRL_IDLE     = 4'd1,
        CTRL_CFG_WAIT = 4'd2,
        CTRL_CFG_REQ  = 4'd3,
        CTRL_CFG_LOAD = 4'd4,
        CTRL_BUSY     = 4'd5,
        CTRL_PAUSE    = 4'd6,
        CTRL_DRAIN    = 4'd7,
        CTRL_DONE     = 4'd8
    } ctrl_state_e;

    // ------------------------------------------------------------------------
    // FIFO sizing
    // ------------------------------------------------------------------------
    localparam int FIFO_DEPTH       = 16;
    localparam int FIFO_PROG_THRESH = 12;
    localparam int PACKET_W         = $bits(data_t) + $bits(addr_t) + $bits(route_t);

endpackage : filter_cond_pkg

`default_nettype wire

// ==== hdl/filter_cond_config_if.sv ====
// Configuration is only meaningful while active is high; the controller is the single driver
`timescale 1ns/1ns
`default_nettype none

interface filter_cond_config_if;

    logic                     active;
    filter_cond_pkg::cmp_op_e op;
    filter_cond_pkg::data_t   operand;
    logic                     conditional;
    filter_cond_pkg::route_t  route_if;
    filter_cond_pkg::route_t  route_else;

    modport ctrl (
        output active, op, operand, conditional, route_if, route_else
    );

    modport kernel (
        input active, op, operand
    );

    modport router (
        input active, conditional, route_if, route_else
    );

endinterface : filter_cond_config_if

`default_nettype wire

// ==== hdl/packet_fifo.sv ====
// Reads of an empty FIFO and writes to a full one are ignored; dout is valid only with valid
`timescale 1ns/1ns
`default_nettype none

module packet_fifo #(
    parameter int WIDTH = 56,
    parameter int DEPTH = 16
) (
    input  logic             ap_clk,
    input  logic             areset_generator,
    input  logic [WIDTH-1:0] din,
    input  logic             wr_en,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             valid,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    // Threshold scales with the depth, same ratio as the default sizing
    localparam int PROG_THRESH =
        filter_cond_pkg::FIFO_PROG_THRESH * DEPTH / filter_cond_pkg::FIFO_DEPTH;

    logic [WIDTH-1:0]  mem [DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   count;
    logic              wr_fire;
    logic              rd_fire;

    assign wr_fire   = wr_en & ~full;
    assign rd_fire   = rd_en & ~empty;
    assign empty     = (count == '0);
    assign full      = (count == (ADDR_W+1)'(DEPTH));
    assign prog_full = (count >= (ADDR_W+1)'(PROG_THRESH));

    always_ff @(posedge ap_clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= din;
        end
        if (rd_fire) begin
            dout <= mem[rd_ptr];
        end
    end

    // Pointers wrap at DEPTH so non power-of-two depths work
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            valid <= rd_fire;
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + (ADDR_W+1)'(wr_fire) - (ADDR_W+1)'(rd_fire);
        end
    end

endmodule : packet_fifo

`default_nettype wire

// ==== hdl/filter_cond_kernel.sv ====
// Compare is unsigned; pass_flag is forced low whenever the configuration is inactive
`timescale 1ns/1ns
`default_nettype none

module filter_cond_kernel (
    input  logic                   ap_clk,
    input  logic                   areset_generator,
    filter_cond_config_if.kernel   cfg,
    input  logic                   data_valid,
    input  filter_cond_pkg::data_t data,
    output logic                   pass_valid,
    output logic                   pass_flag
);

    logic cmp_result;

    always_comb begin
        case (cfg.op)
            filter_cond_pkg::CMP_LT: cmp_result = (data < cfg.operand);
            filter_cond_pkg::CMP_EQ: cmp_result = (data == cfg.operand);
            filter_cond_pkg::CMP_GT: cmp_result = (data > cfg.operand);
            filter_cond_pkg::CMP_NE: cmp_result = (data != cfg.operand);
            default:                 cmp_result = 1'b0;
        endcase
    end

    // One packet per cycle, flag lines up with the router's held fields
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            pass_valid <= 1'b0;
            pass_flag  <= 1'b0;
        end else begin
            pass_valid <= data_valid & cfg.active;
            pass_flag  <= cmp_result & cfg.active;
        end
    end

endmodule : filter_cond_kernel

`default_nettype wire

// ==== hdl/filter_cond_router.sv ====
// Fields are sampled every cycle and must arrive together with the kernel's input word
`timescale 1ns/1ns
`default_nettype none

module filter_cond_router (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    filter_cond_config_if.router    cfg,
    input  logic                    pass_valid,
    input  logic                    pass_flag,
    input  filter_cond_pkg::data_t  data,
    input  filter_cond_pkg::addr_t  addr,
    input  filter_cond_pkg::route_t route,
    output logic                    out_wr,
    output filter_cond_pkg::data_t  out_data,
    output filter_cond_pkg::addr_t  out_addr,
    output filter_cond_pkg::route_t out_route,
    output logic                    busy
);

    filter_cond_pkg::data_t  data_q;
    filter_cond_pkg::addr_t  addr_q;
    filter_cond_pkg::route_t route_q;

    // ------------------------------------------------------------------------
    // Hold stage, parallel to the kernel register
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        data_q  <= data;
        addr_q  <= addr;
        route_q <= route;
    end

    // ------------------------------------------------------------------------
    // Output stage
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            out_wr <= 1'b0;
        end else begin
            // Conditional mode keeps everything, plain mode only passing words
            out_wr <= pass_valid & cfg.active & (cfg.conditional | pass_flag);
        end
    end

    always_ff @(posedge ap_clk) begin
        out_data <= data_q;
        out_addr <= addr_q;
        if (cfg.conditional) begin
            out_route <= pass_flag ? cfg.route_if : cfg.route_else;
        end else begin
            out_route <= route_q;
        end
    end

    assign busy = pass_valid | out_wr;

endmodule : filter_cond_router

`default_nettype wire

// ==== hdl/filter_cond_control.sv ====
// Caller pops input only through in_pop; a start outside CTRL_IDLE is ignored
`timescale 1ns/1ns
`default_nettype none

module filter_cond_control (
    input  logic                     ap_clk,
    input  logic                     areset_generator,
    input  logic                     start,
    input  filter_cond_pkg::count_t  start_count,
    input  logic                     cfg_grant,
    input  logic                     cfg_valid,
    input  filter_cond_pkg::cmp_op_e cfg_op,
    input  filter_cond_pkg::data_t   cfg_operand,
    input  logic                     cfg_conditional,
    input  filter_cond_pkg::route_t  cfg_route_if,
    input  filter_cond_pkg::route_t  cfg_route_else,
    output logic                     cfg_request,
    filter_cond_config_if.ctrl       cfg,
    input  logic                     in_empty,
    input  logic                     out_prog_full,
    input  logic                     pipe_busy,
    output logic                     in_pop,
    output logic                     done
);

    filter_cond_pkg::ctrl_state_e state;
    filter_cond_pkg::ctrl_state_e next_state;
    filter_cond_pkg::count_t      run_count;
    filter_cond_pkg::count_t      pop_count;
    logic                         count_reached;

    assign count_reached = (pop_count == run_count);

    // ------------------------------------------------------------------------
    // State machine
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= filter_cond_pkg::CTRL_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            filter_cond_pkg::CTRL_RESET: next_state = filter_cond_pkg::CTRL_IDLE;
            filter_cond_pkg::CTRL_IDLE: begin
                if (start) next_state = filter_cond_pkg::CTRL_CFG_WAIT;
            end
            filter_cond_pkg::CTRL_CFG_WAIT: begin
                if (cfg_grant) next_state = filter_cond_pkg::CTRL_CFG_REQ;
            end
            filter_cond_pkg::CTRL_CFG_REQ: next_state = filter_cond_pkg::CTRL_CFG_LOAD;
            filter_cond_pkg::CTRL_CFG_LOAD: begin
                if (cfg_valid) next_state = filter_cond_pkg::CTRL_BUSY;
            end
            filter_cond_pkg::CTRL_BUSY: begin
                // Count check first so the last word is never held by a pause
                if (count_reached) begin
                    next_state = filter_cond_pkg::CTRL_DRAIN;
                end else if (out_prog_full) begin
                    next_state = filter_cond_pkg::CTRL_PAUSE;
                end
            end
            filter_cond_pkg::CTRL_PAUSE: begin
                if (!out_prog_full) next_state = filter_cond_pkg::CTRL_BUSY;
            end
            filter_cond_pkg::CTRL_DRAIN: begin
                if (!pipe_busy) next_state = filter_cond_pkg::CTRL_DONE;
            end
            filter_cond_pkg::CTRL_DONE: next_state = filter_cond_pkg::CTRL_IDLE;
            default: next_state = filter_cond_pkg::CTRL_RESET;
        endcase
    end

    assign cfg_request = (state == filter_cond_pkg::CTRL_CFG_REQ);
    assign in_pop      = (state == filter_cond_pkg::CTRL_BUSY) & ~in_empty &
                         ~out_prog_full & ~count_reached;

    // ------------------------------------------------------------------------
    // Run control: done, active and the packet counter
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            done       <= 1'b0;
            cfg.active <= 1'b0;
            run_count  <= '0;
            pop_count  <= '0;
        end else begin
            if (state == filter_cond_pkg::CTRL_IDLE && start) begin
                done      <= 1'b0;
                run_count <= start_count;
                pop_count <= '0;
            end else if (in_pop) begin
                pop_count <= pop_count + 1'b1;
            end
            if (state == filter_cond_pkg::CTRL_CFG_LOAD && cfg_valid) begin
                cfg.active <= 1'b1;
            end
            if (next_state == filter_cond_pkg::CTRL_DONE) begin
                done       <= 1'b1;
                cfg.active <= 1'b0;
            end
        end
    end

    // Configuration word, taken once per run
    always_ff @(posedge ap_clk) begin
        if (state == filter_cond_pkg::CTRL_CFG_LOAD && cfg_valid) begin
            cfg.op          <= cfg_op;
            cfg.operand     <= cfg_operand;
            cfg.conditional <= cfg_conditional;
            cfg.route_if    <= cfg_route_if;
            cfg.route_else  <= cfg_route_else;
        end
    end

endmodule : filter_cond_control

`default_nettype wire

// ==== hdl/filter_cond_generator.sv ====
// The source must not write while in_full is high; out_data is valid only with out_valid
`timescale 1ns/1ns
`default_nettype none

module filter_cond_generator (
    input  logic                     ap_clk,
    input  logic                     areset_generator,
    input  logic                     start,
    input  filter_cond_pkg::count_t  start_count,
    input  logic                     cfg_grant,
    output logic                     cfg_request,
    input  logic                     cfg_valid,
    input  filter_cond_pkg::cmp_op_e cfg_op,
    input  filter_cond_pkg::data_t   cfg_operand,
    input  logic                     cfg_conditional,
    input  filter_cond_pkg::route_t  cfg_route_if,
    input  filter_cond_pkg::route_t  cfg_route_else,
    input  logic                     in_valid,
    input  filter_cond_pkg::data_t   in_data,
    input  filter_cond_pkg::addr_t   in_addr,
    input  filter_cond_pkg::route_t  in_route,
    output logic                     in_full,
    input  logic                     out_pop,
    output logic                     out_valid,
    output filter_cond_pkg::data_t   out_data,
    output filter_cond_pkg::addr_t   out_addr,
    output filter_cond_pkg::route_t  out_route,
    output logic                     done
);

    logic [filter_cond_pkg::PACKET_W-1:0] in_din;
    logic [filter_cond_pkg::PACKET_W-1:0] in_dout;
    logic [filter_cond_pkg::PACKET_W-1:0] out_din;
    logic [filter_cond_pkg::PACKET_W-1:0] out_dout;
    filter_cond_pkg::data_t               fifo_data;
    filter_cond_pkg::addr_t               fifo_addr;
    filter_cond_pkg::route_t              fifo_route;
    filter_cond_pkg::data_t               rt_data;
    filter_cond_pkg::addr_t               rt_addr;
    filter_cond_pkg::route_t              rt_route;
    logic in_pop, in_fifo_valid, in_empty;
    logic pass_valid, pass_flag;
    logic rt_wr, rt_busy, out_prog_full;

    filter_cond_config_if cfg_if ();

    assign in_din                           = {in_data, in_addr, in_route};
    assign {fifo_data, fifo_addr, fifo_route} = in_dout;
    assign out_din                          = {rt_data, rt_addr, rt_route};
    assign {out_data, out_addr, out_route}  = out_dout;

    // ------------------------------------------------------------------------
    // Input side
    // ------------------------------------------------------------------------
    packet_fifo #(
        .WIDTH(filter_cond_pkg::PACKET_W),
        .DEPTH(filter_cond_pkg::FIFO_DEPTH)
    ) in_fifo_inst (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .din(in_din), .wr_en(in_valid), .rd_en(in_pop),
        .dout(in_dout), .valid(in_fifo_valid), .empty(in_empty),
        .full(in_full), .prog_full()
    );

    filter_cond_kernel kernel_inst (
        .ap_clk(ap_clk), .areset_generator(areset_generator), .cfg(cfg_if.kernel),
        .data_valid(in_fifo_valid), .data(fifo_data),
        .pass_valid(pass_valid), .pass_flag(pass_flag)
    );

    filter_cond_router router_inst (
        .ap_clk(ap_clk), .areset_generator(areset_generator), .cfg(cfg_if.router),
        .pass_valid(pass_valid), .pass_flag(pass_flag),
        .data(fifo_data), .addr(fifo_addr), .route(fifo_route),
        .out_wr(rt_wr), .out_data(rt_data), .out_addr(rt_addr), .out_route(rt_route),
        .busy(rt_busy)
    );

    // ------------------------------------------------------------------------
    // Output side and control
    // ------------------------------------------------------------------------
    packet_fifo #(
        .WIDTH(filter_cond_pkg::PACKET_W),
        .DEPTH(filter_cond_pkg::FIFO_DEPTH)
    ) out_fifo_inst (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .din(out_din), .wr_en(rt_wr), .rd_en(out_pop),
        .dout(out_dout), .valid(out_valid), .empty(),
        .full(), .prog_full(out_prog_full)
    );

    filter_cond_control control_inst (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .start(start), .start_count(start_count),
        .cfg_grant(cfg_grant), .cfg_valid(cfg_valid),
        .cfg_op(cfg_op), .cfg_operand(cfg_operand), .cfg_conditional(cfg_conditional),
        .cfg_route_if(cfg_route_if), .cfg_route_else(cfg_route_else),
        .cfg_request(cfg_request), .cfg(cfg_if.ctrl),
        .in_empty(in_empty), .out_prog_full(out_prog_full), .pipe_busy(rt_busy),
        .in_pop(in_pop), .done(done)
    );

endmodule : filter_cond_generator

`default_nettype wire

// ==== verification/filter_cond_checker.sv ====
// Watches controller outputs only; all properties are disabled while reset is high
`timescale 1ns/1ns
`default_nettype none

module filter_cond_checker (
    input logic                         ap_clk,
    input logic                         areset_generator,
    input logic                         cfg_request,
    input logic                         in_pop,
    input logic                         out_prog_full,
    input logic                         done,
    input filter_cond_pkg::ctrl_state_e state
);

    // Request is a strobe, never a level
    request_single_cycle: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        cfg_request |=> !cfg_request
    ) else $error("cfg_request stayed high for more than one cycle");

    no_pop_when_full: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        !(in_pop && out_prog_full)
    ) else $error("in_pop high while the output FIFO is nearly full");

    // done and the state register change on the same edge
    done_rises_in_done_state: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        $rose(done) |-> (state == filter_cond_pkg::CTRL_DONE)
    ) else $error("done rose outside the done state");

endmodule : filter_cond_checker

bind filter_cond_control filter_cond_checker control_checker_inst (
    .ap_clk(ap_clk),
    .areset_generator(areset_generator),
    .cfg_request(cfg_request),
    .in_pop(in_pop),
    .out_prog_full(out_prog_full),
    .done(done),
    .state(state)
);

`default_nettype wire

// ==== verification/filter_cond_generator_tb.sv ====
// Source writes one packet every other cycle and never while in_full is high; runs are sequential
`timescale 1ns/1ns
`default_nettype none

module filter_cond_generator_tb;

    logic                     ap_clk;
    logic                     areset_generator;
    logic                     start;
    filter_cond_pkg::count_t  start_count;
    logic                     cfg_grant;
    logic                     cfg_request;
    logic                     cfg_valid;
    filter_cond_pkg::cmp_op_e cfg_op;
    filter_cond_pkg::data_t   cfg_operand;
    logic                     cfg_conditional;
    filter_cond_pkg::route_t  cfg_route_if;
    filter_cond_pkg::route_t  cfg_route_else;
    logic                     in_valid;
    filter_cond_pkg::data_t   in_data;
    filter_cond_pkg::addr_t   in_addr;
    filter_cond_pkg::route_t  in_route;
    logic                     in_full;
    logic                     out_pop;
    logic                     out_valid;
    filter_cond_pkg::data_t   out_data;
    filter_cond_pkg::addr_t   out_addr;
    filter_cond_pkg::route_t  out_route;
    logic                     done;

    // Packet count of each run sizes the watchdog too
    int                       run_sizes [6] = '{20, 20, 20, 20, 20, 24};
    logic [31:0]              lfsr_state;
    int                       request_count = 0;
    filter_cond_pkg::data_t   exp_data_q [$];
    filter_cond_pkg::addr_t   exp_addr_q [$];
    filter_cond_pkg::route_t  exp_route_q [$];

    filter_cond_generator filter_cond_generator_inst (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .start(start), .start_count(start_count),
        .cfg_grant(cfg_grant), .cfg_request(cfg_request), .cfg_valid(cfg_valid),
        .cfg_op(cfg_op), .cfg_operand(cfg_operand), .cfg_conditional(cfg_conditional),
        .cfg_route_if(cfg_route_if), .cfg_route_else(cfg_route_else),
        .in_valid(in_valid), .in_data(in_data), .in_addr(in_addr), .in_route(in_route),
        .in_full(in_full), .out_pop(out_pop), .out_valid(out_valid),
        .out_data(out_data), .out_addr(out_addr), .out_route(out_route), .done(done)
    );

    initial ap_clk = 1'b0;
    always #4 ap_clk = ~ap_clk;

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at time %0t", $time);
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s: got %0h, expected %0h",
                     $time, what, actual, expected);
            abort_run("a checked value differed from its expected value");
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    // Reference rule returns the keep flag and sets the expected route
    function automatic logic expect_packet(
        input  filter_cond_pkg::data_t   d,
        input  filter_cond_pkg::route_t  r,
        input  filter_cond_pkg::cmp_op_e op,
        input  filter_cond_pkg::data_t   operand,
        input  logic                     cond,
        input  filter_cond_pkg::route_t  rif,
        input  filter_cond_pkg::route_t  relse,
        output filter_cond_pkg::route_t  exp_route
    );
        logic hit;
        case (op)
            filter_cond_pkg::CMP_LT: hit = (d < operand);
            filter_cond_pkg::CMP_EQ: hit = (d == operand);
            filter_cond_pkg::CMP_GT: hit = (d > operand);
            default:                 hit = (d != operand);
        endcase
        if (cond) begin
            exp_route = hit ? rif : relse;
            return 1'b1;
        end
        exp_route = r;
        return hit;
    endfunction

    task automatic send_packet(input filter_cond_pkg::data_t d, input filter_cond_pkg::addr_t a,
                               input filter_cond_pkg::route_t r);
        @(negedge ap_clk);
        while (in_full !== 1'b0) @(negedge ap_clk);
        @(posedge ap_clk);
        in_valid <= 1'b1;
        in_data  <= d;
        in_addr  <= a;
        in_route <= r;
        @(posedge ap_clk);
        in_valid <= 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // One complete run with start, configuration, packets and completion
    // ------------------------------------------------------------------------
    task automatic run_once(input filter_cond_pkg::cmp_op_e op,
                            input filter_cond_pkg::data_t operand,
                            input logic cond, input filter_cond_pkg::route_t rif,
                            input filter_cond_pkg::route_t relse, input int n, input logic stall);
        filter_cond_pkg::data_t  d;
        filter_cond_pkg::addr_t  a;
        filter_cond_pkg::route_t r;
        filter_cond_pkg::route_t er;
        int                      req_before;
        @(posedge ap_clk);
        start       <= 1'b1;
        start_count <= filter_cond_pkg::count_t'(n);
        @(posedge ap_clk);
        start      <= 1'b0;
        req_before = request_count;
        repeat (3) @(negedge ap_clk);
        check_value(done, 1'b0, "done after start");
        check_value(request_count, req_before, "cfg_request pulses before grant");
        @(posedge ap_clk);
        cfg_grant <= 1'b1;
        @(negedge ap_clk);
        while (cfg_request !== 1'b1) @(negedge ap_clk);
        @(posedge ap_clk);
        cfg_valid       <= 1'b1;
        cfg_op          <= op;
        cfg_operand     <= operand;
        cfg_conditional <= cond;
        cfg_route_if    <= rif;
        cfg_route_else  <= relse;
        @(posedge ap_clk);
        cfg_valid <= 1'b0;
        cfg_grant <= 1'b0;
        out_pop   <= ~stall;
        for (int i = 0; i < n; i++) begin
            d = (rand_bits(2) == 0) ? rand_bits(32) : rand_bits(3);
            a = filter_cond_pkg::addr_t'(rand_bits(16));
            r = filter_cond_pkg::route_t'(rand_bits(8));
            if (expect_packet(d, r, op, operand, cond, rif, relse, er)) begin
                exp_data_q.push_back(d);
                exp_addr_q.push_back(a);
                exp_route_q.push_back(er);
            end
            send_packet(d, a, r);
        end
        if (stall) begin
            repeat (40) @(negedge ap_clk);
            check_value(filter_cond_generator_inst.out_fifo_inst.count <
                        filter_cond_pkg::FIFO_DEPTH, 1'b1, "output FIFO filled while stalled");
            check_value(filter_cond_generator_inst.out_fifo_inst.count >=
                        filter_cond_pkg::FIFO_PROG_THRESH, 1'b1, "output FIFO below threshold");
            check_value(done, 1'b0, "done while output is stalled");
            @(posedge ap_clk);
            out_pop <= 1'b1;
        end
        @(negedge ap_clk);
        while (done !== 1'b1) @(negedge ap_clk);
        while (exp_data_q.size() != 0) @(negedge ap_clk);
        repeat (5) @(negedge ap_clk);
        check_value(request_count, req_before + 1, "cfg_request pulses in one run");
    endtask

    // ------------------------------------------------------------------------
    // Monitors
    // ------------------------------------------------------------------------
    always @(negedge ap_clk) begin
        if (cfg_request === 1'b1) begin
            request_count <= request_count + 1;
        end
    end

    always @(negedge ap_clk) begin
        if (out_valid === 1'b1) begin
            check_value(exp_data_q.size() != 0, 1'b1, "output packet with none expected");
            check_value(out_data, exp_data_q.pop_front(), "output data");
            check_value(out_addr, exp_addr_q.pop_front(), "output address");
            check_value(out_route, exp_route_q.pop_front(), "output route");
        end
    end

    initial begin
        int total;
        total = 0;
        foreach (run_sizes[i]) total += run_sizes[i];
        repeat (total * 200 + 1000) @(posedge ap_clk);
        abort_run("Timeout: the runs did not complete in the allowed number of cycles");
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        lfsr_state       = 32'h50dbcca7;
        areset_generator = 1'b1;
        start            = 1'b0;
        start_count      = '0;
        cfg_grant        = 1'b0;
        cfg_valid        = 1'b0;
        cfg_op           = filter_cond_pkg::CMP_LT;
        cfg_operand      = '0;
        cfg_conditional  = 1'b0;
        cfg_route_if     = '0;
        cfg_route_else   = '0;
        in_valid         = 1'b0;
        in_data          = '0;
        in_addr          = '0;
        in_route         = '0;
        out_pop          = 1'b1;
        repeat (2) @(posedge ap_clk);
        areset_generator <= 1'b0;
        repeat (2) @(negedge ap_clk);
        check_value(done, 1'b0, "done after reset");
        check_value(cfg_request, 1'b0, "cfg_request after reset");
        check_value(out_valid, 1'b0, "out_valid after reset");
        check_value(in_full, 1'b0, "in_full after reset");

        // Plain filter per operator followed by conditional runs and a stalled consumer
        run_once(filter_cond_pkg::CMP_LT, 32'd5, 1'b0, 8'h00, 8'h00, run_sizes[0], 1'b0);
        run_once(filter_cond_pkg::CMP_EQ, 32'd5, 1'b0, 8'h00, 8'h00, run_sizes[1], 1'b0);
        run_once(filter_cond_pkg::CMP_GT, 32'd3, 1'b0, 8'h00, 8'h00, run_sizes[2], 1'b0);
        run_once(filter_cond_pkg::CMP_NE, 32'd2, 1'b0, 8'h00, 8'h00, run_sizes[3], 1'b0);
        run_once(filter_cond_pkg::CMP_GT, 32'd3, 1'b1, 8'ha1, 8'h5e, run_sizes[4], 1'b0);
        run_once(filter_cond_pkg::CMP_NE, 32'd4, 1'b1, 8'h3c, 8'hc3, run_sizes[5], 1'b1);

        if (exp_data_q.size() == 0 && done === 1'b1) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            abort_run("Expected packets were left over or done was low at the end");
        end
    end

endmodule : filter_cond_generator_tb

`default_nettype wire

// ==== filter_cond_generator.f ====
hdl/filter_cond_pkg.sv
hdl/filter_cond_config_if.sv
hdl/packet_fifo.sv
hdl/filter_cond_kernel.sv
hdl/filter_cond_router.sv
hdl/filter_cond_control.sv
hdl/filter_cond_generator.sv
verification/filter_cond_checker.sv
verification/filter_cond_generator_tb.sv

// ==== Bender.yml ====
package:
  name: filter_cond_generator

sources:
  - files:
      - hdl/filter_cond_pkg.sv
      - hdl/filter_cond_config_if.sv
      - hdl/packet_fifo.sv
      - hdl/filter_cond_kernel.sv
      - hdl/filter_cond_router.sv
      - hdl/filter_cond_control.sv
      - hdl/filter_cond_generator.sv
  - target: test
    files:
      - verification/filter_cond_checker.sv
      - verification/filter_cond_generator_tb.sv
